// ==== list.f ====
src/csr_pkg.sv
src/csr_exc_detect.sv
src/csr_int_select.sv
src/csr_counters.sv
src/csr_regs.sv
src/csr_unit.sv
dv/tb_csr_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run tb_csr_unit with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_csr_unit \
    -o sim_csr_unit > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_csr_unit > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log && ! grep -q "TB FAILED" sim.log

// ==== dv/tb_csr_unit.sv ====
// Directed testbench of the machine-mode CSR unit.
// Inputs change on the falling edge and outputs are sampled 10 ns later.
// Counter checks assume CNT_WIDTH 64 and a low mcycle word far from wrapping.
`timescale 1ns/100ps

module tb_csr_unit;
    import csr_pkg::*;

    localparam logic [31:0] HART_ID   = 32'h0000_0005;
    localparam int          NUM_TESTS = 6;
    localparam logic [31:0] EXC_BASE  = 32'h0000_0100;
    localparam logic [31:0] INT_BASE  = 32'h0000_0200;
    localparam logic [1:0]  GRP_REG   = 2'b00;
    localparam logic [1:0]  GRP_CNT   = 2'b10;
    localparam ictrl_t      UNIT_LSU  = 7'd1 << ICTRL_UNIT_LSU;
    localparam ictrl_t      UNIT_CSR  = 7'd1 << ICTRL_UNIT_CSR;
    localparam logic [11:0] ECALL_PL  = {1'b0, CSR_FUN_ECALL, 9'h060};    // machine CSR bits set
    localparam logic [11:0] EBREAK_PL = {1'b0, CSR_FUN_EBREAK, 9'h060};
    localparam logic [11:0] MRET_PL   = {1'b0, CSR_FUN_RET, 9'h060};

    logic        s_clk_i, s_resetn_i;
    ictrl_t      s_ictrl_i;
    f_part_t     s_function_i;
    logic [11:0] s_payload_i;
    logic [31:0] s_val_i, s_rstpoint_i;
    imiscon_t    s_imiscon_i;
    logic        s_hresp_i, s_stall_i, s_flush_i, s_interrupted_i;
    logic        s_int_meip_i, s_int_mtip_i, s_int_msip_i;
    logic [31:0] s_csr_r_val_o, s_exc_trap_o, s_int_trap_o;
    logic        s_exception_o, s_int_pending_o, s_mret_o;
    int          errors, checks;
    integer      seed;

    csr_unit #(.CNT_WIDTH(64), .HART_ID(HART_ID)) dut_i (.*);

    initial begin
        s_clk_i = 1'b0;
        forever #50 s_clk_i = ~s_clk_i;
    end

    function automatic logic [31:0] status_word(input logic mie, input logic mpie);
        logic [31:0] w;
        w                   = 32'h0000_1800;    // MPP reads 11
        w[MSTATUS_MIE_BIT]  = mie;
        w[MSTATUS_MPIE_BIT] = mpie;
        return w;
    endfunction

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic drive_idle;
        s_ictrl_i    = '0;
        s_function_i = 4'b0000;
        s_payload_i  = 12'h000;
        s_val_i      = 32'h0;
        s_imiscon_i  = IMISCON_NONE;
        s_hresp_i    = 1'b0;
        s_rstpoint_i = 32'h0;
        s_stall_i    = 1'b0;
        s_flush_i    = 1'b0;
    endtask

    // one CSR instruction for one cycle, then idle
    task automatic csr_op(input csr_op_t op, input logic [1:0] grp, input logic [4:0] idx,
                          input logic [31:0] data, input logic flush);
        @(negedge s_clk_i);
        s_ictrl_i    = UNIT_CSR;
        s_function_i = {2'b00, op};
        s_payload_i  = {3'b000, grp, 2'b11, idx};
        s_val_i      = data;
        s_flush_i    = flush;
        @(negedge s_clk_i);
        drive_idle;
    endtask

    task automatic csr_read(input logic [4:0] idx, output logic [31:0] val);
        @(negedge s_clk_i);
        drive_idle;
        s_payload_i = {3'b000, GRP_REG, 2'b11, idx};
        #10;
        val = s_csr_r_val_o;
    endtask

    task automatic expect_csr(input string what, input logic [4:0] idx, input logic [31:0] exp);
        logic [31:0] rd;
        csr_read(idx, rd);
        check_word(what, rd, exp);
    endtask

    task automatic test_reset;
        logic [4:0]  idx;
        logic [31:0] exp;
        for (int i = 0; i < 16; i++) begin
            idx = i[4:0];
            if (idx == MCSR_CYCLE)
                continue;                       // already running
            exp = (idx == MCSR_STATUS) ? status_word(1'b0, 1'b0)
                : (idx == MCSR_HARTID) ? HART_ID
                : (idx == MCSR_ISA) ? MISA_VALUE : 32'h0;
            expect_csr($sformatf("reset value of csr %0d", idx), idx, exp);
        end
        check_bit("exception after reset", s_exception_o, 1'b0);
        check_bit("pending after reset", s_int_pending_o, 1'b0);
        check_bit("mret after reset", s_mret_o, 1'b0);
    endtask

    task automatic test_csr_ops;
        logic [31:0] model, data;
        data = $random(seed);
        csr_op(CSR_RW, GRP_REG, MCSR_SCRATCH, data, 1'b0);
        model = data;
        expect_csr("mscratch after RW", MCSR_SCRATCH, model);
        data = $random(seed);
        csr_op(CSR_RS, GRP_REG, MCSR_SCRATCH, data, 1'b0);
        model = model | data;
        expect_csr("mscratch after RS", MCSR_SCRATCH, model);
        data = $random(seed);
        csr_op(CSR_RC, GRP_REG, MCSR_SCRATCH, data, 1'b0);
        model = model & ~data;
        expect_csr("mscratch after RC", MCSR_SCRATCH, model);
        csr_op(CSR_RW, GRP_REG, MCSR_TVEC, 32'hFFFF_FFFF, 1'b0);
        expect_csr("mtvec bit 1", MCSR_TVEC, 32'hFFFF_FFFD);
        csr_op(CSR_RW, GRP_REG, MCSR_STATUS, 32'hFFFF_FFFF, 1'b0);
        expect_csr("mstatus all ones", MCSR_STATUS, status_word(1'b1, 1'b1));
        csr_op(CSR_RW, GRP_REG, MCSR_STATUS, 32'h0, 1'b0);
        expect_csr("mstatus cleared", MCSR_STATUS, status_word(1'b0, 1'b0));
        csr_op(CSR_RW, GRP_REG, MCSR_SCRATCH, ~model, 1'b1);
        expect_csr("mscratch after flushed write", MCSR_SCRATCH, model);
    endtask

    task automatic exc_case(input string name, input ictrl_t ictrl, input f_part_t func,
                            input logic [11:0] payload, input imiscon_t imis, input logic hresp,
                            input logic [31:0] val, input logic [4:0] code);
        logic [31:0] epc, tval;
        epc  = 32'h0000_4000 + 32'(code) * 4;
        tval = (code == EXC_LADD_MISS_VAL || code == EXC_SADD_MISS_VAL) ? val : 32'h0;
        csr_op(CSR_RW, GRP_REG, MCSR_STATUS, status_word(1'b1, 1'b0), 1'b0);
        @(negedge s_clk_i);
        s_ictrl_i    = ictrl;
        s_function_i = func;
        s_payload_i  = payload;
        s_imiscon_i  = imis;
        s_hresp_i    = hresp;
        s_val_i      = val;
        s_rstpoint_i = epc;
        #10;
        check_bit({name, ": exception"}, s_exception_o, 1'b1);
        check_word({name, ": trap address"}, s_exc_trap_o, EXC_BASE);
        @(negedge s_clk_i);
        drive_idle;
        expect_csr({name, ": mcause"}, MCSR_CAUSE, {27'd0, code});
        expect_csr({name, ": mepc"}, MCSR_EPC, epc);
        expect_csr({name, ": mtval"}, MCSR_TVAL, tval);
        expect_csr({name, ": mstatus"}, MCSR_STATUS, status_word(1'b0, 1'b1));
    endtask

    task automatic test_exceptions;
        csr_op(CSR_RW, GRP_REG, MCSR_TVEC, EXC_BASE | 32'h1, 1'b0);   // vectored mode
        exc_case("fetch fault", '0, 4'b0000, 12'h0, IMISCON_FERR, 1'b0, 32'h0, EXC_IACCESS_VAL);
        exc_case("load misaligned", UNIT_LSU, 4'b0010, 12'h0, IMISCON_NONE, 1'b0,
                 32'h0000_1002, EXC_LADD_MISS_VAL);
        exc_case("illegal", '0, 4'b0000, 12'h0, IMISCON_ILLE, 1'b0, 32'h1234, EXC_ILLEGALI_VAL);
        exc_case("ecall", UNIT_CSR, 4'b0000, ECALL_PL, IMISCON_NONE, 1'b0, 32'h0, EXC_ECALL_VAL);
        exc_case("store misaligned", UNIT_LSU, 4'b1001, 12'h0, IMISCON_NONE, 1'b0,
                 32'h0000_2003, EXC_SADD_MISS_VAL);
        exc_case("ebreak", UNIT_CSR, 4'b0000, EBREAK_PL, IMISCON_NONE, 1'b0, 32'h0, EXC_EBREAK_VAL);
        exc_case("load access", UNIT_LSU, 4'b0010, 12'h0, IMISCON_NONE, 1'b1,
                 32'h0000_3000, EXC_LACCESS_VAL);
        exc_case("store access", UNIT_LSU, 4'b1010, 12'h0, IMISCON_NONE, 1'b1,
                 32'h0000_3004, EXC_SACCESS_VAL);
        // two causes at once, higher priority wins
        exc_case("illegal over ecall", UNIT_CSR, 4'b0000, ECALL_PL, IMISCON_ILLE, 1'b0,
                 32'h0, EXC_ILLEGALI_VAL);
        exc_case("misaligned over access", UNIT_LSU, 4'b0010, 12'h0, IMISCON_NONE, 1'b1,
                 32'h0000_3001, EXC_LADD_MISS_VAL);
    endtask

    task automatic check_irq(input string what, input logic [4:0] code);
        @(negedge s_clk_i);                     // mip samples on the edge between
        #10;
        check_bit({what, ": pending"}, s_int_pending_o, 1'b1);
        check_word({what, ": vectored address"}, s_int_trap_o, INT_BASE + 32'(code) * 4);
    endtask

    task automatic test_interrupts;
        csr_op(CSR_RW, GRP_REG, MCSR_TVEC, INT_BASE | 32'h1, 1'b0);
        csr_op(CSR_RW, GRP_REG, MCSR_IE, 32'hFFFF_FFFF, 1'b0);
        expect_csr("mie writable bits", MCSR_IE, 32'h0000_0888);
        csr_op(CSR_RW, GRP_REG, MCSR_STATUS, status_word(1'b1, 1'b0), 1'b0);
        @(negedge s_clk_i);
        s_int_mtip_i = 1'b1;
        check_irq("timer", INT_MTI_VAL);
        @(negedge s_clk_i);
        s_int_msip_i = 1'b1;
        check_irq("software over timer", INT_MSI_VAL);
        @(negedge s_clk_i);
        s_int_meip_i = 1'b1;
        check_irq("external over all", INT_MEI_VAL);
        @(negedge s_clk_i);
        s_interrupted_i = 1'b1;
        @(negedge s_clk_i);
        s_interrupted_i = 1'b0;
        expect_csr("mcause after interrupt", MCSR_CAUSE, 32'h8000_0000 | 32'(INT_MEI_VAL));
        expect_csr("mstatus after interrupt", MCSR_STATUS, status_word(1'b0, 1'b1));
        check_bit("pending with MIE clear", s_int_pending_o, 1'b0);
        @(negedge s_clk_i);
        s_int_meip_i = 1'b0;
        s_int_mtip_i = 1'b0;
        s_int_msip_i = 1'b0;
    endtask

    // mret from a given mstatus, MIE takes MPIE and MPIE is set
    task automatic mret_case(input logic mie, input logic mpie);
        csr_op(CSR_RW, GRP_REG, MCSR_STATUS, status_word(mie, mpie), 1'b0);
        @(negedge s_clk_i);
        s_ictrl_i   = UNIT_CSR;
        s_payload_i = MRET_PL;
        #10;
        check_bit("mret strobe", s_mret_o, 1'b1);
        check_bit("no exception on mret", s_exception_o, 1'b0);
        @(negedge s_clk_i);
        drive_idle;
        expect_csr("mstatus after mret", MCSR_STATUS, status_word(mpie, 1'b1));
    endtask

    task automatic test_mret;
        mret_case(1'b0, 1'b1);
        mret_case(1'b1, 1'b0);
        check_bit("mret when idle", s_mret_o, 1'b0);
    endtask

    // aligned word loads, count cycles each
    task automatic issue(input int count, input logic stall, input logic flush);
        repeat (count) begin
            @(negedge s_clk_i);
            s_ictrl_i    = UNIT_LSU;
            s_function_i = 4'b0010;
            s_val_i      = 32'h0000_0100;
            s_stall_i    = stall;
            s_flush_i    = flush;
        end
        @(negedge s_clk_i);
        drive_idle;
    endtask

    task automatic test_counters;
        logic [31:0] c0, c1, data;
        csr_read(MCSR_CYCLE, c0);
        repeat (9) @(negedge s_clk_i);
        csr_read(MCSR_CYCLE, c1);
        check_word("mcycle over 10 cycles", c1 - c0, 32'd10);
        csr_read(MCSR_INSTRET, c0);
        issue(3, 1'b0, 1'b0);
        issue(2, 1'b1, 1'b0);
        issue(2, 1'b0, 1'b1);
        csr_read(MCSR_INSTRET, c1);
        check_word("minstret retired count", c1 - c0, 32'd3);
        data = $random(seed);
        csr_op(CSR_RW, GRP_CNT, MCSR_CYCLEH, data, 1'b0);
        expect_csr("mcycleh write", MCSR_CYCLEH, data);
    endtask

    initial begin
        seed            = 93911;
        errors          = 0;
        checks          = 0;
        s_resetn_i      = 1'b0;
        s_interrupted_i = 1'b0;
        s_int_meip_i    = 1'b0;
        s_int_mtip_i    = 1'b0;
        s_int_msip_i    = 1'b0;
        drive_idle;
        repeat (8) @(posedge s_clk_i);
        @(negedge s_clk_i);
        s_resetn_i = 1'b1;
        test_reset;
        test_csr_ops;
        test_exceptions;
        test_interrupts;
        test_mret;
        test_counters;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial begin
        #(NUM_TESTS * 200 * 100);
        $display("watchdog expired, tests did not finish within %0d cycles", NUM_TESTS * 200);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== src/csr_unit.sv ====
// Machine-mode CSR unit of the memory-access stage.
// All outputs are combinational; register updates show one edge later.
// CNT_WIDTH sets the counter width (33 to 64).
`timescale 1ns/100ps

module csr_unit #(
    parameter int          CNT_WIDTH = 64,
    parameter logic [31:0] HART_ID   = 32'd0
) (
    input  logic              s_clk_i,
    input  logic              s_resetn_i,
    input  csr_pkg::ictrl_t   s_ictrl_i,
    input  csr_pkg::f_part_t  s_function_i,
    input  logic [11:0]       s_payload_i,
    input  logic [31:0]       s_val_i,
    input  csr_pkg::imiscon_t s_imiscon_i,
    input  logic              s_hresp_i,
    input  logic [31:0]       s_rstpoint_i,
    input  logic              s_stall_i,
    input  logic              s_flush_i,
    input  logic              s_interrupted_i,  // pipeline takes the interrupt
    input  logic              s_int_meip_i,
    input  logic              s_int_mtip_i,
    input  logic              s_int_msip_i,
    output logic [31:0]       s_csr_r_val_o,
    output logic              s_exception_o,
    output logic [31:0]       s_exc_trap_o,
    output logic [31:0]       s_int_trap_o,
    output logic              s_int_pending_o,
    output logic              s_mret_o
);
    logic                 s_trap, s_tval_we;
    logic [31:0]          s_cause, s_tval, s_csr_w_val;
    logic [31:0]          s_mstatus, s_mie, s_mip, s_mtvec;
    logic [4:0]           s_int_code;
    logic [3:0]           s_cnt_we;
    logic [CNT_WIDTH-1:0] s_mcycle, s_minstret;

    csr_exc_detect u_exc_detect (
        .s_ictrl_i(s_ictrl_i), .s_function_i(s_function_i), .s_payload_i(s_payload_i),
        .s_val_i(s_val_i), .s_imiscon_i(s_imiscon_i), .s_hresp_i(s_hresp_i),
        .s_interrupted_i(s_interrupted_i), .s_int_code_i(s_int_code),
        .s_exception_o(s_exception_o), .s_trap_o(s_trap), .s_cause_o(s_cause),
        .s_tval_we_o(s_tval_we), .s_tval_o(s_tval)
    );

    csr_int_select u_int_select (
        .s_mstatus_i(s_mstatus), .s_mie_i(s_mie), .s_mip_i(s_mip), .s_mtvec_i(s_mtvec),
        .s_int_pending_o(s_int_pending_o), .s_int_code_o(s_int_code),
        .s_exc_trap_o(s_exc_trap_o), .s_int_trap_o(s_int_trap_o)
    );

    csr_counters #(.CNT_WIDTH(CNT_WIDTH)) u_counters (
        .s_clk_i(s_clk_i), .s_resetn_i(s_resetn_i), .s_ictrl_i(s_ictrl_i),
        .s_stall_i(s_stall_i), .s_flush_i(s_flush_i), .s_cnt_we_i(s_cnt_we),
        .s_csr_w_val_i(s_csr_w_val), .s_mcycle_o(s_mcycle), .s_minstret_o(s_minstret)
    );

    csr_regs #(.CNT_WIDTH(CNT_WIDTH), .HART_ID(HART_ID)) u_regs (
        .s_clk_i(s_clk_i), .s_resetn_i(s_resetn_i), .s_ictrl_i(s_ictrl_i),
        .s_function_i(s_function_i), .s_payload_i(s_payload_i), .s_val_i(s_val_i),
        .s_flush_i(s_flush_i), .s_rstpoint_i(s_rstpoint_i),
        .s_int_meip_i(s_int_meip_i), .s_int_mtip_i(s_int_mtip_i), .s_int_msip_i(s_int_msip_i),
        .s_trap_i(s_trap), .s_cause_i(s_cause), .s_tval_we_i(s_tval_we), .s_tval_i(s_tval),
        .s_mcycle_i(s_mcycle), .s_minstret_i(s_minstret),
        .s_csr_r_val_o(s_csr_r_val_o), .s_mret_o(s_mret_o),
        .s_mstatus_o(s_mstatus), .s_mie_o(s_mie), .s_mip_o(s_mip), .s_mtvec_o(s_mtvec),
        .s_cnt_we_o(s_cnt_we), .s_csr_w_val_o(s_csr_w_val)
    );

endmodule

// ==== src/csr_regs.sv ====
// Machine CSR registers with read mux, RW/RS/RC modify, trap entry and mret.
// Reads ignore the address group, writes need group 00 (registers) or 10 (counters).
// mstatus keeps only MIE and MPIE; MPP always reads 11.
`timescale 1ns/100ps

module csr_regs #(
    parameter int          CNT_WIDTH = 64,
    parameter logic [31:0] HART_ID   = 32'd0
) (
    input  logic                 s_clk_i,
    input  logic                 s_resetn_i,
    input  csr_pkg::ictrl_t      s_ictrl_i,
    input  csr_pkg::f_part_t     s_function_i,
    input  logic [11:0]          s_payload_i,
    input  logic [31:0]          s_val_i,       // source operand of the CSR op
    input  logic                 s_flush_i,
    input  logic [31:0]          s_rstpoint_i,  // address of the current instruction
    input  logic                 s_int_meip_i,
    input  logic                 s_int_mtip_i,
    input  logic                 s_int_msip_i,
    input  logic                 s_trap_i,
    input  logic [31:0]          s_cause_i,
    input  logic                 s_tval_we_i,
    input  logic [31:0]          s_tval_i,
    input  logic [CNT_WIDTH-1:0] s_mcycle_i,
    input  logic [CNT_WIDTH-1:0] s_minstret_i,
    output logic [31:0]          s_csr_r_val_o,
    output logic                 s_mret_o,
    output logic [31:0]          s_mstatus_o,
    output logic [31:0]          s_mie_o,
    output logic [31:0]          s_mip_o,
    output logic [31:0]          s_mtvec_o,
    output logic [3:0]           s_cnt_we_o,
    output logic [31:0]          s_csr_w_val_o
);
    import csr_pkg::*;

    localparam logic [31:0] IRQ_MASK = (32'd1 << IRQ_MSI_BIT) | (32'd1 << IRQ_MTI_BIT)
                                     | (32'd1 << IRQ_MEI_BIT);

    mcsr_idx_t   s_csr_add;
    logic        s_machine_csr, s_grp_reg, s_grp_cnt, s_sys_fun, s_csr_op, s_wr_reg, s_wr_cnt;
    logic        s_st_mie_q, s_st_mpie_q;
    logic [31:0] s_mie_q, s_mip_q, s_mtvec_q, s_mepc_q, s_mcause_q, s_mtval_q, s_mscratch_q;
    logic [31:0] s_mstatus, s_mip_d;
    logic [63:0] s_cycle_ext, s_instret_ext;

    assign s_csr_add     = mcsr_idx_t'(s_payload_i[4:0]);
    assign s_machine_csr = &s_payload_i[6:5];
    assign s_grp_reg     = (s_payload_i[8:7] == 2'b00);
    assign s_grp_cnt     = (s_payload_i[8:7] == 2'b10);
    assign s_sys_fun     = s_ictrl_i[ICTRL_UNIT_CSR] & (s_function_i[2:0] == 3'b000);
    assign s_csr_op      = (|s_function_i[1:0]) & s_ictrl_i[ICTRL_UNIT_CSR] & s_machine_csr
                         & ~s_flush_i;
    assign s_wr_reg      = s_csr_op & s_grp_reg;
    assign s_wr_cnt      = s_csr_op & s_grp_cnt;
    assign s_mret_o      = s_sys_fun & s_machine_csr & s_grp_reg
                         & (s_payload_i[10:9] == CSR_FUN_RET) & ~s_flush_i;

    always_comb begin
        s_mstatus                   = 32'b0;
        s_mstatus[12:11]            = 2'b11;    // MPP, M-mode only
        s_mstatus[MSTATUS_MIE_BIT]  = s_st_mie_q;
        s_mstatus[MSTATUS_MPIE_BIT] = s_st_mpie_q;
    end

    always_comb begin
        s_mip_d              = 32'b0;
        s_mip_d[IRQ_MSI_BIT] = s_int_msip_i;
        s_mip_d[IRQ_MTI_BIT] = s_int_mtip_i;
        s_mip_d[IRQ_MEI_BIT] = s_int_meip_i;
    end

    assign s_cycle_ext   = 64'(s_mcycle_i);     // high word zero-extended
    assign s_instret_ext = 64'(s_minstret_i);

    always_comb begin
        case (s_csr_add)
            MCSR_STATUS:   s_csr_r_val_o = s_mstatus;
            MCSR_IE:       s_csr_r_val_o = s_mie_q;
            MCSR_TVEC:     s_csr_r_val_o = s_mtvec_q;
            MCSR_EPC:      s_csr_r_val_o = s_mepc_q;
            MCSR_CAUSE:    s_csr_r_val_o = s_mcause_q;
            MCSR_TVAL:     s_csr_r_val_o = s_mtval_q;
            MCSR_IP:       s_csr_r_val_o = s_mip_q;
            MCSR_CYCLE:    s_csr_r_val_o = s_cycle_ext[31:0];
            MCSR_CYCLEH:   s_csr_r_val_o = s_cycle_ext[63:32];
            MCSR_INSTRET:  s_csr_r_val_o = s_instret_ext[31:0];
            MCSR_INSTRETH: s_csr_r_val_o = s_instret_ext[63:32];
            MCSR_SCRATCH:  s_csr_r_val_o = s_mscratch_q;
            MCSR_HARTID:   s_csr_r_val_o = HART_ID;
            MCSR_ISA:      s_csr_r_val_o = MISA_VALUE;
            default:       s_csr_r_val_o = 32'b0;
        endcase
    end

    always_comb begin
        case (csr_op_t'(s_function_i[1:0]))
            CSR_RW:  s_csr_w_val_o = s_val_i;
            CSR_RS:  s_csr_w_val_o = s_csr_r_val_o | s_val_i;
            CSR_RC:  s_csr_w_val_o = s_csr_r_val_o & ~s_val_i;
            default: s_csr_w_val_o = s_csr_r_val_o;
        endcase
    end

    assign s_cnt_we_o = {s_wr_cnt & (s_csr_add == MCSR_INSTRETH),
                         s_wr_cnt & (s_csr_add == MCSR_INSTRET),
                         s_wr_cnt & (s_csr_add == MCSR_CYCLEH),
                         s_wr_cnt & (s_csr_add == MCSR_CYCLE)};

    always_ff @(posedge s_clk_i) begin
        if (!s_resetn_i) begin
            s_st_mie_q   <= 1'b0;
            s_st_mpie_q  <= 1'b0;
            s_mie_q      <= 32'b0;
            s_mip_q      <= 32'b0;
            s_mtvec_q    <= 32'b0;
            s_mepc_q     <= 32'b0;
            s_mcause_q   <= 32'b0;
            s_mtval_q    <= 32'b0;
            s_mscratch_q <= 32'b0;
        end else begin
            s_mip_q <= s_mip_d;                 // sampled every cycle
            if (s_trap_i) begin
                s_mepc_q    <= s_rstpoint_i;
                s_mcause_q  <= s_cause_i;
                s_st_mpie_q <= s_st_mie_q;
                s_st_mie_q  <= 1'b0;
                if (s_tval_we_i)
                    s_mtval_q <= s_tval_i;
            end else if (s_mret_o) begin
                s_st_mie_q  <= s_st_mpie_q;
                s_st_mpie_q <= 1'b1;
            end else if (s_wr_reg) begin
                case (s_csr_add)
                    MCSR_STATUS: begin
                        s_st_mie_q  <= s_csr_w_val_o[MSTATUS_MIE_BIT];
                        s_st_mpie_q <= s_csr_w_val_o[MSTATUS_MPIE_BIT];
                    end
                    MCSR_IE:      s_mie_q      <= s_csr_w_val_o & IRQ_MASK;
                    MCSR_TVEC:    s_mtvec_q    <= {s_csr_w_val_o[31:2], 1'b0, s_csr_w_val_o[0]};
                    MCSR_EPC:     s_mepc_q     <= s_csr_w_val_o;
                    MCSR_CAUSE:   s_mcause_q   <= s_csr_w_val_o;
                    MCSR_TVAL:    s_mtval_q    <= s_csr_w_val_o;
                    MCSR_SCRATCH: s_mscratch_q <= s_csr_w_val_o;
                    default: ;                  // read-only or absent
                endcase
            end
        end
    end

    assign s_mstatus_o = s_mstatus;
    assign s_mie_o     = s_mie_q;
    assign s_mip_o     = s_mip_q;
    assign s_mtvec_o   = s_mtvec_q;

    // pipeline never approves a trap on the cycle of a return
    a_trap_mret_excl: assert property (@(posedge s_clk_i) disable iff (!s_resetn_i)
        !(s_trap_i && s_mret_o))
        else $error("trap entry and mret in the same cycle");

endmodule

// ==== src/csr_counters.sv ====
// mcycle and minstret counters, CNT_WIDTH bits each (33 to 64).
// A word write replaces one half and the other half holds for that cycle.
`timescale 1ns/100ps

module csr_counters #(
    parameter int CNT_WIDTH = 64
) (
    input  logic                 s_clk_i,
    input  logic                 s_resetn_i,
    input  csr_pkg::ictrl_t      s_ictrl_i,
    input  logic                 s_stall_i,
    input  logic                 s_flush_i,
    input  logic [3:0]           s_cnt_we_i,    // instreth, instret, cycleh, cycle
    input  logic [31:0]          s_csr_w_val_i,
    output logic [CNT_WIDTH-1:0] s_mcycle_o,
    output logic [CNT_WIDTH-1:0] s_minstret_o
);
    localparam int HI_W = CNT_WIDTH - 32;

    logic [CNT_WIDTH-1:0] s_mcycle_q, s_minstret_q;
    logic                 s_commit;

    assign s_commit = (s_ictrl_i != '0) & ~s_stall_i & ~s_flush_i;

    always_ff @(posedge s_clk_i) begin
        if (!s_resetn_i) begin
            s_mcycle_q   <= '0;
            s_minstret_q <= '0;
        end else begin
            if (s_cnt_we_i[0])
                s_mcycle_q[31:0] <= s_csr_w_val_i;
            else if (s_cnt_we_i[1])
                s_mcycle_q[CNT_WIDTH-1:32] <= s_csr_w_val_i[HI_W-1:0];
            else
                s_mcycle_q <= s_mcycle_q + 1'b1;    // free running

            if (s_cnt_we_i[2])
                s_minstret_q[31:0] <= s_csr_w_val_i;
            else if (s_cnt_we_i[3])
                s_minstret_q[CNT_WIDTH-1:32] <= s_csr_w_val_i[HI_W-1:0];
            else if (s_commit)
                s_minstret_q <= s_minstret_q + 1'b1;
        end
    end

    assign s_mcycle_o   = s_mcycle_q;
    assign s_minstret_o = s_minstret_q;

    // decode upstream addresses one counter word per instruction
    a_cnt_we_onehot: assert property (@(posedge s_clk_i) disable iff (!s_resetn_i)
        $onehot0(s_cnt_we_i))
        else $error("several counter words written at once: %b", s_cnt_we_i);

endmodule

// ==== src/csr_int_select.sv ====
// Interrupt pending logic and trap-handler addresses.
// Priority is MEI, MSI, MTI. Code reads 0 when no enabled source is set.
`timescale 1ns/100ps

module csr_int_select (
    input  logic [31:0] s_mstatus_i,
    input  logic [31:0] s_mie_i,
    input  logic [31:0] s_mip_i,
    input  logic [31:0] s_mtvec_i,
    output logic        s_int_pending_o,
    output logic [4:0]  s_int_code_o,
    output logic [31:0] s_exc_trap_o,
    output logic [31:0] s_int_trap_o
);
    import csr_pkg::*;

    logic [31:0] s_active, s_vectored;

    assign s_active        = s_mie_i & s_mip_i;
    assign s_int_pending_o = (|s_active) & s_mstatus_i[MSTATUS_MIE_BIT];

    always_comb begin
        if (s_active[IRQ_MEI_BIT])      s_int_code_o = INT_MEI_VAL;
        else if (s_active[IRQ_MSI_BIT]) s_int_code_o = INT_MSI_VAL;
        else if (s_active[IRQ_MTI_BIT]) s_int_code_o = INT_MTI_VAL;
        else                            s_int_code_o = 5'd0;
    end

    assign s_exc_trap_o = {s_mtvec_i[31:2], 2'b00};                  // mode bits masked
    assign s_vectored   = s_exc_trap_o + {25'b0, s_int_code_o, 2'b00}; // base + 4*code
    assign s_int_trap_o = s_mtvec_i[0] ? s_vectored : s_exc_trap_o;

endmodule

// ==== src/csr_exc_detect.sv ====
// Exception detection and trap cause for the memory-access stage.
// Purely combinational. An approved interrupt takes precedence over any exception.
`timescale 1ns/100ps

module csr_exc_detect (
    input  csr_pkg::ictrl_t   s_ictrl_i,
    input  csr_pkg::f_part_t  s_function_i,
    input  logic [11:0]       s_payload_i,
    input  logic [31:0]       s_val_i,          // LSU address or ALU result
    input  csr_pkg::imiscon_t s_imiscon_i,
    input  logic              s_hresp_i,        // bus error of the data transfer
    input  logic              s_interrupted_i,
    input  logic [4:0]        s_int_code_i,
    output logic              s_exception_o,
    output logic              s_trap_o,
    output logic [31:0]       s_cause_o,
    output logic              s_tval_we_o,
    output logic [31:0]       s_tval_o
);
    import csr_pkg::*;

    logic       s_lsu, s_sys_fun, s_misaligned;
    logic       s_exc_iacc, s_exc_ille, s_exc_ecall, s_exc_ebreak, s_exc_miss, s_exc_lsacc;
    logic [4:0] s_exc_code;

    assign s_lsu        = s_ictrl_i[ICTRL_UNIT_LSU];
    assign s_sys_fun    = s_ictrl_i[ICTRL_UNIT_CSR] & (s_function_i[2:0] == 3'b000);
    assign s_misaligned = (|s_val_i[1:0] & s_function_i[1]) | (s_val_i[0] & s_function_i[0]);

    assign s_exc_iacc   = (s_imiscon_i == IMISCON_FERR);
    assign s_exc_ille   = (s_imiscon_i == IMISCON_ILLE);
    assign s_exc_ecall  = s_sys_fun & (s_payload_i[10:9] == CSR_FUN_ECALL);
    assign s_exc_ebreak = s_sys_fun & (s_payload_i[10:9] == CSR_FUN_EBREAK);
    assign s_exc_miss   = s_lsu & s_misaligned;
    assign s_exc_lsacc  = s_lsu & s_hresp_i;

    assign s_exception_o = s_exc_iacc | s_exc_ille | s_exc_ecall | s_exc_ebreak
                         | s_exc_miss | s_exc_lsacc;

    always_comb begin
        if (s_exc_iacc)        s_exc_code = EXC_IACCESS_VAL;
        else if (s_exc_ille)   s_exc_code = EXC_ILLEGALI_VAL;
        else if (s_exc_ecall)  s_exc_code = EXC_ECALL_VAL;
        else if (s_exc_ebreak) s_exc_code = EXC_EBREAK_VAL;
        else if (s_exc_miss)   s_exc_code = s_function_i[3] ? EXC_SADD_MISS_VAL : EXC_LADD_MISS_VAL;
        else                   s_exc_code = s_function_i[3] ? EXC_SACCESS_VAL : EXC_LACCESS_VAL;
    end

    assign s_trap_o    = s_interrupted_i | s_exception_o;
    assign s_cause_o   = {s_interrupted_i, 26'b0, s_interrupted_i ? s_int_code_i : s_exc_code};
    assign s_tval_we_o = s_exception_o & ~s_interrupted_i;     // interrupts leave mtval
    assign s_tval_o    = ((s_exc_code == EXC_LADD_MISS_VAL) | (s_exc_code == EXC_SADD_MISS_VAL))
                       ? s_val_i : 32'b0;

    // an approved interrupt must have a pending source behind it
    always_comb begin
        if (s_trap_o) begin
            assert (s_cause_o[31] ? (s_cause_o[4:0] inside {INT_MSI_VAL, INT_MTI_VAL, INT_MEI_VAL})
                                  : (s_cause_o[4:0] != 5'd0))
                else $error("trap taken with unknown cause %h", s_cause_o);
        end
    end

endmodule

// ==== src/csr_pkg.sv ====
// Shared definitions of the machine-mode CSR unit.
// Only M-mode exists; CSR indices are the compressed 5-bit form carried in payload bits 4:0.
package csr_pkg;

    // compressed CSR index in payload bits 4:0
    typedef enum logic [4:0] {
        MCSR_STATUS   = 5'd0,
        MCSR_IE       = 5'd1,
        MCSR_TVEC     = 5'd2,
        MCSR_EPC      = 5'd3,
        MCSR_CAUSE    = 5'd4,
        MCSR_TVAL     = 5'd5,
        MCSR_IP       = 5'd6,
        MCSR_CYCLE    = 5'd7,
        MCSR_CYCLEH   = 5'd8,
        MCSR_INSTRET  = 5'd9,
        MCSR_INSTRETH = 5'd10,
        MCSR_SCRATCH  = 5'd11,
        MCSR_HARTID   = 5'd12,
        MCSR_ISA      = 5'd13
    } mcsr_idx_t;

    typedef enum logic [1:0] {
        IMISCON_NONE = 2'b00,
        IMISCON_ILLE = 2'b01,                   // illegal instruction
        IMISCON_FERR = 2'b10                    // fetch bus error
    } imiscon_t;

    typedef logic [6:0] ictrl_t;                // one flag per functional unit
    localparam int ICTRL_UNIT_LSU = 3;
    localparam int ICTRL_UNIT_CSR = 5;

    typedef logic [3:0] f_part_t;               // bit 3 store, bit 1 word, bit 0 half-word

    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

    // system function in payload bits 10:9
    localparam logic [1:0] CSR_FUN_ECALL  = 2'b00;
    localparam logic [1:0] CSR_FUN_EBREAK = 2'b01;
    localparam logic [1:0] CSR_FUN_RET    = 2'b10;

    localparam logic [4:0] IRQ_MSI_BIT = 5'd3;
    localparam logic [4:0] IRQ_MTI_BIT = 5'd7;
    localparam logic [4:0] IRQ_MEI_BIT = 5'd11;

    localparam logic [4:0] MSTATUS_MIE_BIT  = 5'd3;
    localparam logic [4:0] MSTATUS_MPIE_BIT = 5'd7;

    localparam logic [4:0] EXC_IACCESS_VAL   = 5'd1;
    localparam logic [4:0] EXC_ILLEGALI_VAL  = 5'd2;
    localparam logic [4:0] EXC_EBREAK_VAL    = 5'd3;
    localparam logic [4:0] EXC_LADD_MISS_VAL = 5'd4;
    localparam logic [4:0] EXC_LACCESS_VAL   = 5'd5;
    localparam logic [4:0] EXC_SADD_MISS_VAL = 5'd6;
    localparam logic [4:0] EXC_SACCESS_VAL   = 5'd7;
    localparam logic [4:0] EXC_ECALL_VAL     = 5'd11;

    localparam logic [4:0] INT_MSI_VAL = 5'd3;
    localparam logic [4:0] INT_MTI_VAL = 5'd7;
    localparam logic [4:0] INT_MEI_VAL = 5'd11;

    localparam logic [31:0] MISA_VALUE = 32'h4000_0100;    // MXL=1, I extension

endpackage
